// File: mvm_data_pkg.sv
`default_nettype none

package mvm_data_pkg;

   typedef logic [11:0] addr_t;   // memory address
   typedef logic [15:0] word_t;   // memory data word
   typedef logic [15:0] elem_t;   // one element, zero-extended
   typedef logic [35:0] acc_t;    // 16 products of 16x16 fit
   typedef logic [4:0]  width_t;  // 2, 4, 8 or 16

   // anything unexpected falls back to full words
   function automatic width_t legal_width(input word_t hdr);
      case (hdr)
         16'd2:   return width_t'(2);
         16'd4:   return width_t'(4);
         16'd8:   return width_t'(8);
         default: return width_t'(16);
      endcase
   endfunction

   function automatic width_t elems_per_word(input width_t w);
      case (w)
         5'd2:    return width_t'(8);
         5'd4:    return width_t'(4);
         5'd8:    return width_t'(2);
         default: return width_t'(1);
      endcase
   endfunction

endpackage

`default_nettype wire

// File: mvm_ctrl_pkg.sv
`default_nettype none

package mvm_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE,
      HDR_ADDR,   // header word 0 address out
      HDR_A,      // counts arrive
      HDR_B,      // widths arrive
      LOAD,       // input vector words
      ROW_END,    // gap between rows, first weight word captured here
      ROW,        // one element per cycle
      FINISH
   } ctrl_state_t;

   // header layout, same in both memories
   localparam int unsigned HDR_COUNT = 0;
   localparam int unsigned HDR_WIDTH = 1;
   localparam int unsigned DATA_BASE = 2;

endpackage

`default_nettype wire

// File: mvm_controller.sv
`default_nettype none

module mvm_controller (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  dut_run,
   input  mvm_data_pkg::word_t   sram_word,
   input  mvm_data_pkg::word_t   wmem_word,
   input  logic                  col_last,
   input  logic                  row_last,
   input  logic                  load_done,
   input  logic                  word_last,
   output logic                  dut_busy,
   output logic                  clear,
   output logic                  in_step,
   output logic                  col_step,
   output logic                  row_step,
   output logic                  load_word,
   output logic                  fetch_word,
   output logic                  acc_valid,
   output logic                  row_end,
   output mvm_data_pkg::word_t   num_inputs,
   output mvm_data_pkg::word_t   num_rows,
   output mvm_data_pkg::width_t  in_width,
   output mvm_data_pkg::width_t  w_width
);
   import mvm_data_pkg::*;
   import mvm_ctrl_pkg::*;

   ctrl_state_t state, state_next;
   logic        first_row;   // ROW_END right after LOAD only primes the weight word

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         dut_busy   <= 1'b0;
         first_row  <= 1'b0;
         num_inputs <= '0;
         num_rows   <= '0;
         in_width   <= '0;
         w_width    <= '0;
      end else begin
         state <= state_next;
         case (state)
            IDLE:    dut_busy <= clear;   // also drops busy after FINISH
            HDR_A: begin
               num_inputs <= sram_word;
               num_rows   <= wmem_word;
            end
            HDR_B: begin
               in_width <= legal_width(sram_word);
               w_width  <= legal_width(wmem_word);
            end
            LOAD:    first_row <= load_done;
            ROW_END: first_row <= 1'b0;
            default: ;
         endcase
      end
   end

   always_comb begin
      state_next = state;
      clear      = 1'b0;
      in_step    = 1'b0;
      col_step   = 1'b0;
      row_step   = 1'b0;
      load_word  = 1'b0;
      fetch_word = 1'b0;
      acc_valid  = 1'b0;
      row_end    = 1'b0;
      case (state)
         IDLE: begin
            if (dut_run && !dut_busy) begin
               clear      = 1'b1;
               state_next = HDR_ADDR;
            end
         end
         HDR_ADDR: begin
            in_step    = 1'b1;
            state_next = HDR_A;
         end
         HDR_A: begin
            in_step    = 1'b1;
            state_next = HDR_B;
         end
         HDR_B: begin
            in_step    = 1'b1;
            state_next = LOAD;
         end
         LOAD: begin
            load_word = 1'b1;
            if (load_done) state_next = ROW_END;
            else in_step = 1'b1;
         end
         ROW_END: begin
            fetch_word = 1'b1;         // first word of the coming row
            row_step   = !first_row;
            state_next = ROW;
         end
         ROW: begin
            acc_valid = 1'b1;
            if (col_last) begin
               row_end    = 1'b1;
               state_next = row_last ? FINISH : ROW_END;
            end else begin
               col_step   = 1'b1;
               fetch_word = word_last;  // next column starts a fresh word
            end
         end
         FINISH:  state_next = IDLE;
         default: state_next = IDLE;
      endcase
   end

   // busy still high when the closing row's result is written
   a_row_end_busy: assert property (@(posedge clk) disable iff (rst)
      row_end |-> ##2 dut_busy);

endmodule

`default_nettype wire

// File: mvm_index_counter.sv
`default_nettype none

module mvm_index_counter #(
   parameter int MAX_N = 16
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clear,
   input  logic                         in_step,
   input  logic                         col_step,
   input  logic                         row_step,
   input  mvm_data_pkg::word_t          num_inputs,
   input  mvm_data_pkg::word_t          num_rows,
   input  mvm_data_pkg::width_t         in_width,
   input  mvm_data_pkg::width_t         w_width,
   output mvm_data_pkg::addr_t          dut_sram_read_address,
   output mvm_data_pkg::addr_t          dut_wmem_read_address,
   output logic [$clog2(MAX_N)-1:0]     col,
   output logic                         col_last,
   output logic                         row_last,
   output logic                         load_done,
   output logic                         word_last
);
   import mvm_data_pkg::*;
   import mvm_ctrl_pkg::*;

   addr_t  in_addr;
   addr_t  wbase;      // first word of the row being prefetched
   word_t  wpos;       // prefetch element position, num_inputs is the row gap
   word_t  row;
   word_t  n_eff, r_eff, in_words, row_words;
   width_t w_epw;
   logic [2:0] in_shift, w_shift;

   function automatic logic [2:0] shift_of(input width_t w);
      case (w)
         5'd2:    return 3'd3;
         5'd4:    return 3'd2;
         5'd8:    return 3'd1;
         default: return 3'd0;
      endcase
   endfunction

   assign n_eff     = (num_inputs == '0) ? word_t'(1) : num_inputs;
   assign r_eff     = (num_rows == '0) ? word_t'(1) : num_rows;
   assign in_shift  = shift_of(in_width);
   assign w_shift   = shift_of(w_width);
   assign w_epw     = elems_per_word(w_width);
   assign in_words  = ((n_eff - 1'b1) >> in_shift) + 1'b1;
   assign row_words = ((n_eff - 1'b1) >> w_shift) + 1'b1;

   // data for in_addr - 1 is on the bus
   assign load_done = (in_addr == addr_t'(DATA_BASE) + addr_t'(in_words));
   assign col_last  = (word_t'(col) == n_eff - 1'b1);
   assign row_last  = (row == r_eff - 1'b1);
   assign word_last = ((width_t'(col) & (w_epw - 1'b1)) == w_epw - 1'b1);

   assign dut_sram_read_address = in_addr;
   assign dut_wmem_read_address = (in_addr <= addr_t'(HDR_WIDTH)) ? in_addr :
                                  wbase + addr_t'(wpos >> w_shift);

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         in_addr <= addr_t'(HDR_COUNT);
         wbase   <= addr_t'(DATA_BASE);
         wpos    <= '0;
         col     <= '0;
         row     <= '0;
      end else begin
         if (in_step) in_addr <= in_addr + 1'b1;
         // weight stream runs two slots ahead from the last load cycle on
         if (load_done) begin
            if (wpos == n_eff) begin
               wpos  <= '0;
               wbase <= wbase + addr_t'(row_words);
            end else begin
               wpos <= wpos + 1'b1;
            end
         end
         if (row_step) begin
            col <= '0;
            row <= row + 1'b1;
         end else if (col_step) begin
            col <= col + 1'b1;
         end
      end
   end

   // a column step never wraps the counter past the buffer
   a_col_range: assert property (@(posedge clk) disable iff (rst)
      col_step |-> (int'(col) < MAX_N - 1));

endmodule

`default_nettype wire

// File: mvm_input_buffer.sv
`default_nettype none

module mvm_input_buffer #(
   parameter int MAX_N = 16
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      clear,
   input  logic                      load_word,
   input  mvm_data_pkg::word_t       word_in,
   input  mvm_data_pkg::width_t      in_width,
   input  logic [$clog2(MAX_N)-1:0]  col,
   output mvm_data_pkg::elem_t       elem
);
   import mvm_data_pkg::*;

   elem_t                   vec [MAX_N];
   logic [$clog2(MAX_N):0]  slot;     // next free element
   width_t                  epw;
   logic [16:0]             mask;

   assign epw  = elems_per_word(in_width);
   assign mask = (17'd1 << in_width) - 1'b1;
   assign elem = vec[col];

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         slot <= '0;
      end else if (load_word) begin
         slot <= slot + epw;
      end
   end

   // lowest field first, overflow slots are dropped
   always_ff @(posedge clk) begin
      if (load_word) begin
         for (int i = 0; i < 8; i++) begin
            if (i < int'(epw) && int'(slot) + i < MAX_N)
               vec[int'(slot) + i] <= elem_t'((word_in >> (i * in_width)) & mask[15:0]);
         end
      end
   end

   a_slot_bound: assert property (@(posedge clk) disable iff (rst)
      load_word |=> (int'(slot) <= MAX_N));

endmodule

`default_nettype wire

// File: mvm_weight_unpacker.sv
`default_nettype none

module mvm_weight_unpacker #(
   parameter int MAX_N = 16
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      fetch_word,
   input  mvm_data_pkg::word_t       word_in,
   input  mvm_data_pkg::width_t      w_width,
   input  logic [$clog2(MAX_N)-1:0]  col,
   output mvm_data_pkg::elem_t       elem
);
   import mvm_data_pkg::*;

   word_t       held;        // current weight word
   width_t      field;
   logic [16:0] mask;

   assign field = width_t'(col) & (elems_per_word(w_width) - 1'b1);
   assign mask  = (17'd1 << w_width) - 1'b1;
   assign elem  = elem_t'((held >> (field * w_width)) & mask[15:0]);

   always_ff @(posedge clk) begin
      if (rst) held <= '0;
      else if (fetch_word) held <= word_in;
   end

endmodule

`default_nettype wire

// File: mvm_mac.sv
`default_nettype none

module mvm_mac (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clear,
   input  logic                 acc_valid,
   input  logic                 row_end,
   input  mvm_data_pkg::elem_t  in_elem,
   input  mvm_data_pkg::elem_t  w_elem,
   output mvm_data_pkg::addr_t  dut_sram_write_address,
   output mvm_data_pkg::word_t  dut_sram_write_data,
   output logic                 dut_sram_write_enable
);
   import mvm_data_pkg::*;

   logic [31:0] prod;
   logic        prod_valid, prod_end;
   acc_t        acc, sum;
   addr_t       res_addr;

   assign sum = acc + (prod_valid ? acc_t'(prod) : '0);

   always_ff @(posedge clk) prod <= in_elem * w_elem;

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         prod_valid            <= 1'b0;
         prod_end              <= 1'b0;
         acc                   <= '0;
         res_addr              <= '0;
         dut_sram_write_enable <= 1'b0;
      end else begin
         prod_valid            <= acc_valid;
         prod_end              <= row_end;
         dut_sram_write_enable <= prod_end;
         if (prod_end) begin
            acc                    <= '0;   // next row starts clean
            dut_sram_write_address <= res_addr;
            dut_sram_write_data    <= sum[15:0];
            res_addr               <= res_addr + 1'b1;
         end else begin
            acc <= sum;
         end
      end
   end

   a_we_pulse: assert property (@(posedge clk) disable iff (rst)
      dut_sram_write_enable |=> !dut_sram_write_enable);

endmodule

`default_nettype wire

// File: mvm_top.sv
`default_nettype none

module mvm_top #(
   parameter int MAX_N = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 dut_run,
   input  mvm_data_pkg::word_t  sram_dut_read_data,
   input  mvm_data_pkg::word_t  wmem_dut_read_data,
   output logic                 dut_busy,
   output mvm_data_pkg::addr_t  dut_sram_read_address,
   output mvm_data_pkg::addr_t  dut_wmem_read_address,
   output mvm_data_pkg::addr_t  dut_sram_write_address,
   output mvm_data_pkg::word_t  dut_sram_write_data,
   output logic                 dut_sram_write_enable
);
   import mvm_data_pkg::*;

   logic clear, in_step, col_step, row_step;
   logic load_word, fetch_word, acc_valid, row_end;
   logic col_last, row_last, load_done, word_last;
   logic [$clog2(MAX_N)-1:0] col;
   word_t  num_inputs, num_rows;
   width_t in_width, w_width;
   elem_t  in_elem, w_elem;

   mvm_controller u_ctrl (
      .clk, .rst, .dut_run,
      .sram_word (sram_dut_read_data),
      .wmem_word (wmem_dut_read_data),
      .col_last, .row_last, .load_done, .word_last,
      .dut_busy, .clear, .in_step, .col_step, .row_step,
      .load_word, .fetch_word, .acc_valid, .row_end,
      .num_inputs, .num_rows, .in_width, .w_width
   );

   mvm_index_counter #(.MAX_N(MAX_N)) u_cnt (
      .clk, .rst, .clear, .in_step, .col_step, .row_step,
      .num_inputs, .num_rows, .in_width, .w_width,
      .dut_sram_read_address, .dut_wmem_read_address,
      .col, .col_last, .row_last, .load_done, .word_last
   );

   mvm_input_buffer #(.MAX_N(MAX_N)) u_inbuf (
      .clk, .rst, .clear, .load_word,
      .word_in (sram_dut_read_data),
      .in_width, .col,
      .elem    (in_elem)
   );

   mvm_weight_unpacker #(.MAX_N(MAX_N)) u_wunp (
      .clk, .rst, .fetch_word,
      .word_in (wmem_dut_read_data),
      .w_width, .col,
      .elem    (w_elem)
   );

   mvm_mac u_mac (
      .clk, .rst, .clear, .acc_valid, .row_end,
      .in_elem, .w_elem,
      .dut_sram_write_address, .dut_sram_write_data, .dut_sram_write_enable
   );

endmodule

`default_nettype wire

// File: tb_checker.sv
`default_nettype none

module tb_checker (
   input  logic        clk,
   input  logic        rst,
   input  logic        dut_busy,
   input  logic        write_enable,
   input  logic [11:0] write_address,
   input  logic [15:0] sram_img [4096],
   input  logic [15:0] wmem_img [4096],
   input  logic [15:0] result_img [4096],
   input  int          test_id,
   input  int          jobs_started,
   output int          value_errors,
   output int          protocol_errors
);
   timeunit 1ns;
   timeprecision 1ps;

   int   writes;      // results seen in the current job
   int   jobs_seen;
   logic busy_q;

   function automatic string test_name(input int id);
      case (id)
         0:       return "reset_idle";
         1:       return "fixed_8x8";
         2:       return "mixed_2x16";
         3:       return "mixed_4x8";
         4:       return "random";
         default: return "back_to_back";
      endcase
   endfunction

   // header width, unknown codes mean full words
   function automatic int width_of(input logic [15:0] hdr);
      if (hdr == 16'd2 || hdr == 16'd4 || hdr == 16'd8) return int'(hdr);
      return 16;
   endfunction

   function automatic int field(input logic [15:0] word, input int pos, input int w);
      return (int'(word) >> (pos * w)) & ((1 << w) - 1);
   endfunction

   // dot product of row r with the input vector, low 16 bits
   function automatic logic [15:0] row_ref(input int r);
      int          n, iw, ww, row_words, x, w;
      logic [63:0] sum;
      n         = int'(sram_img[0]);
      iw        = width_of(sram_img[1]);
      ww        = width_of(wmem_img[1]);
      row_words = (n * ww + 15) / 16;   // rows start on a fresh word
      sum       = '0;
      for (int k = 0; k < n; k++) begin
         x   = field(sram_img[2 + k / (16 / iw)], k % (16 / iw), iw);
         w   = field(wmem_img[2 + r * row_words + k / (16 / ww)], k % (16 / ww), ww);
         sum = sum + 64'(longint'(x) * longint'(w));
      end
      return sum[15:0];
   endfunction

   task automatic check_job();
      int          rows;
      logic [15:0] exp;
      rows = int'(wmem_img[0]);
      if (writes != rows) begin
         $display("%s: job wrote %0d results, expected %0d", test_name(test_id), writes, rows);
         protocol_errors++;
      end
      for (int r = 0; r < rows; r++) begin
         exp = row_ref(r);
         if (result_img[r] !== exp) begin
            $display("error %s row %0d expected %h actual %h",
                     test_name(test_id), r, exp, result_img[r]);
            value_errors++;
         end
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         busy_q          = 1'b0;
         writes          = 0;
         jobs_seen       = 0;
         value_errors    = 0;
         protocol_errors = 0;
      end else begin
         if (dut_busy && !busy_q) begin
            jobs_seen++;
            writes = 0;
            if (jobs_seen > jobs_started) begin
               $display("busy rose without a run request");
               protocol_errors++;
            end
         end
         if (write_enable) begin
            if (!dut_busy) begin
               $display("write enable high while the design is idle");
               protocol_errors++;
            end else if (int'(write_address) != writes) begin
               $display("result written to address %0d, expected %0d",
                        write_address, writes);
               protocol_errors++;
            end
            writes++;
         end
         if (!dut_busy && busy_q) check_job();   // job just ended
         busy_q = dut_busy;
      end
   end

endmodule

`default_nettype wire

// File: tb_top.sv
`default_nettype none

module tb_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_N     = 16;
   localparam int MEM_WORDS = 4096;

   logic        clk;
   logic        rst;
   logic        dut_run;
   logic [15:0] sram_dut_read_data;
   logic [15:0] wmem_dut_read_data;
   logic        dut_busy;
   logic [11:0] dut_sram_read_address;
   logic [11:0] dut_wmem_read_address;
   logic [11:0] dut_sram_write_address;
   logic [15:0] dut_sram_write_data;
   logic        dut_sram_write_enable;

   logic [15:0] sram_mem [MEM_WORDS];
   logic [15:0] wmem_mem [MEM_WORDS];
   logic [15:0] result_mem [MEM_WORDS];   // captured result writes
   logic [31:0] rng_state;
   int          test_id, jobs_started, timeouts;
   int          value_errors, protocol_errors;

   mvm_top #(.MAX_N(MAX_N)) DUT (.*);

   tb_checker chk (
      .clk, .rst, .dut_busy,
      .write_enable  (dut_sram_write_enable),
      .write_address (dut_sram_write_address),
      .sram_img      (sram_mem),
      .wmem_img      (wmem_mem),
      .result_img    (result_mem),
      .test_id, .jobs_started, .value_errors, .protocol_errors
   );

   always #10 clk = ~clk;

   // both memories answer one cycle after the address
   always @(posedge clk) begin
      sram_dut_read_data <= sram_mem[dut_sram_read_address];
      wmem_dut_read_data <= wmem_mem[dut_wmem_read_address];
      if (dut_sram_write_enable) result_mem[dut_sram_write_address] <= dut_sram_write_data;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int rand_below(input int range);
      rng_state = xorshift32(rng_state);
      return int'(rng_state % 32'(range));
   endfunction

   // read-modify-write of one packed field
   task automatic put_elem(input bit to_wmem, input int word, input int pos,
                           input int width, input int val);
      logic [15:0] mask, fld;
      int          shift;
      shift = pos * width;
      mask  = 16'(((32'd1 << width) - 1) << shift);
      fld   = 16'(val << shift) & mask;
      if (to_wmem) wmem_mem[word] = (wmem_mem[word] & ~mask) | fld;
      else sram_mem[word] = (sram_mem[word] & ~mask) | fld;
   endtask

   task automatic build_job(input int id, input int n, input int r, input int iw,
                            input int ww, input bit fixed);
      int row_words, val, k, row, a;
      test_id <= id;
      sram_mem[0] = 16'(n);
      sram_mem[1] = 16'(iw);
      wmem_mem[0] = 16'(r);
      wmem_mem[1] = 16'(ww);
      row_words = (n * ww + 15) / 16;
      for (k = 0; k < n; k++) begin
         val = fixed ? k + 1 : rand_below(1 << iw);
         put_elem(1'b0, 2 + k / (16 / iw), k % (16 / iw), iw, val);
      end
      for (row = 0; row < r; row++) begin
         for (k = 0; k < n; k++) begin
            val = fixed ? 16 * row + k + 3 : rand_below(1 << ww);
            put_elem(1'b1, 2 + row * row_words + k / (16 / ww), k % (16 / ww), ww, val);
         end
      end
      for (a = 0; a < MEM_WORDS; a++) result_mem[a] = 16'(a * 40503) ^ 16'hc3a5;
   endtask

   task automatic end_sim();
      repeat (3) @(posedge clk);
      $display("errors: value %0d, protocol %0d, timeout %0d",
               value_errors, protocol_errors, timeouts);
      if (value_errors + protocol_errors + timeouts == 0) $display("sim passed");
      else $display("sim failed");
      $finish;
   endtask

   task automatic wait_busy(input logic level, input int limit);
      int cycles;
      cycles = 0;
      while (dut_busy !== level && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (dut_busy !== level) begin
         $display("timeout: busy did not go %s within %0d cycles",
                  level ? "high" : "low", limit);
         timeouts++;
      end
   endtask

   // hold keeps run high for a few cycles into the job
   task automatic run_job(input int hold);
      if (timeouts != 0) return;   // no new jobs once the design hung
      @(posedge clk);
      dut_run      <= 1'b1;
      jobs_started <= jobs_started + 1;
      wait_busy(1'b1, 20);
      repeat (hold) @(posedge clk);
      dut_run <= 1'b0;
      wait_busy(1'b0, 2000);
      repeat (3) @(posedge clk);
   endtask

   initial begin
      int n, r, iw, ww, i, a;
      clk                = 1'b0;
      rst                = 1'b1;
      dut_run            = 1'b0;
      sram_dut_read_data = '0;
      wmem_dut_read_data = '0;
      rng_state          = 32'd40898;
      test_id            = 0;
      jobs_started       = 0;
      timeouts           = 0;
      for (a = 0; a < MEM_WORDS; a++) begin
         sram_mem[a] = 16'(a * 26417) ^ 16'h5a5a;
         wmem_mem[a] = 16'(a * 52813) ^ 16'h0ff0;
      end
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      repeat (20) @(posedge clk);   // idle, checker flags any activity

      build_job(1, 4, 3, 8, 8, 1'b1);
      run_job(0);
      build_job(2, 6, 2, 2, 16, 1'b0);
      run_job(0);
      build_job(3, 10, 4, 4, 8, 1'b0);
      run_job(0);

      for (i = 0; i < 12; i++) begin
         n  = 1 + rand_below(16);
         r  = 1 + rand_below(16);
         iw = 2 << rand_below(4);
         ww = 2 << rand_below(4);
         build_job(4, n, r, iw, ww, 1'b0);
         run_job(0);
      end

      // two jobs in a row, run held into busy
      for (i = 0; i < 2; i++) begin
         n  = 1 + rand_below(16);
         r  = 1 + rand_below(16);
         iw = 2 << rand_below(4);
         ww = 2 << rand_below(4);
         build_job(5, n, r, iw, ww, 1'b0);
         run_job(3);
      end
      end_sim();
   end

endmodule

`default_nettype wire

// File: compile.f
mvm_data_pkg.sv
mvm_ctrl_pkg.sv
mvm_controller.sv
mvm_index_counter.sv
mvm_input_buffer.sv
mvm_weight_unpacker.sv
mvm_mac.sv
mvm_top.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
